// ==== hdl/pfu_pkg.sv ====
// shared prefetch definitions; addresses are halfword or word granular, fetches are always 32-bit
`default_nettype none

package pfu_pkg;

   // ----------------------------------------------------------------------
   // address widths
   // ----------------------------------------------------------------------

   // halfword address, byte address bits 31:1
   localparam int HADDR_W = 31;

   // word address, byte address bits 31:2
   localparam int WADDR_W = 30;

   // first halfword fetched once reset is released
   localparam logic [HADDR_W-1:0] RESET_HADDR = '0;

   // ----------------------------------------------------------------------
   // opcode classification
   // ----------------------------------------------------------------------

   // kind of opcode handed to the decoder
   // breakpoint wins over fault when both apply to one halfword
   typedef enum logic [1:0] {
      OP_INSTR = 2'd0,
      OP_BKPT  = 2'd1,
      OP_FAULT = 2'd2
   } op_kind_e;

   // special opcode patterns, only meaningful with op_special set
   //   breakpoint  0100_0000_0000_0000
   //   fault       0000_0000_0000_0000
   localparam logic [15:0] BKPT_OPCODE  = 16'h4000;
   localparam logic [15:0] FAULT_OPCODE = 16'h0000;

   // ----------------------------------------------------------------------
   // instruction buffer entry
   // ----------------------------------------------------------------------

   // one fetched word plus its tags, 66 bits
   //   waddr    word address the data came from
   //   data     raw read data, upper half is the higher halfword
   //   err      bus error on the fetch, applies to both halves
   //   bkpt     breakpoint match, bit 1 upper half, bit 0 lower half
   //   skip_lo  branch target was halfword aligned, lower half is dead
   typedef struct packed {
      logic [WADDR_W-1:0] waddr;
      logic [31:0]        data;
      logic               err;
      logic [1:0]         bkpt;
      logic               skip_lo;
   } ibuf_entry_t;

endpackage

`default_nettype wire

// ==== hdl/pfu_if.sv ====
// buffer write and read bundles; no clock inside, all signals are sampled on hclk by the modules
`default_nettype none

// ----------------------------------------------------------------------
// write side, fetch generator into word buffer
// ----------------------------------------------------------------------

// credit flow control, one credit per free buffer entry
// the producer never writes without a credit in hand
interface pfu_wr_if;

   // a tagged response word, written on the edge it is valid
   logic                 wr_valid;
   pfu_pkg::ibuf_entry_t wr_entry;

   // branch redirect, empties the buffer on the same edge
   logic                 flush;

   // one pulse per entry popped by the consumer
   logic                 credit_ret;

   modport producer (
      output wr_valid,
      output wr_entry,
      output flush,
      input  credit_ret
   );

   modport buffer (
      input  wr_valid,
      input  wr_entry,
      input  flush,
      output credit_ret
   );

endinterface

// ----------------------------------------------------------------------
// read side, word buffer into opcode issue
// ----------------------------------------------------------------------

// head of the buffer is always visible
// rd_pop only while rd_valid is high
interface pfu_rd_if;

   logic                 rd_valid;
   pfu_pkg::ibuf_entry_t rd_entry;
   logic                 rd_pop;

   modport buffer (
      output rd_valid,
      output rd_entry,
      input  rd_pop
   );

   modport consumer (
      input  rd_valid,
      input  rd_entry,
      output rd_pop
   );

endinterface

`default_nettype wire

// ==== hdl/pfu_fetch_gen.sv ====
// fetch producer; bus must answer in grant order, in-flight fetches incl. stale ones <= MAX_OUTST
`default_nettype none

module pfu_fetch_gen #(
   parameter int IBUF_WORDS = 4,
   parameter int MAX_OUTST  = 2
) (
   input  wire                         hclk,
   input  wire                         hreset_n,
   input  wire                         branch_i,
   input  wire [pfu_pkg::HADDR_W-1:0]  branch_target_i,
   output logic                        fetch_req_o,
   output logic [pfu_pkg::WADDR_W-1:0] fetch_addr_o,
   input  wire                         fetch_gnt_i,
   input  wire                         rsp_valid_i,
   input  wire [31:0]                  rsp_rdata_i,
   input  wire                         rsp_err_i,
   input  wire [1:0]                   rsp_bkpt_i,
   pfu_wr_if.producer                  wr
);

   localparam int CW = $clog2(IBUF_WORDS + 1);
   localparam int OW = $clog2(MAX_OUTST + 1);
   localparam int QW = (MAX_OUTST > 1) ? $clog2(MAX_OUTST) : 1;

   // ----------------------------------------------------------------------
   // state
   // ----------------------------------------------------------------------

   // low only in the first cycle out of reset, keeps the request quiet
   logic                        run_q;
   logic [pfu_pkg::WADDR_W-1:0] next_waddr_q;
   // next granted word is a halfword-aligned branch target
   logic                        skip_pend_q;
   logic [CW-1:0]               credits_q;
   // live fetches, their responses go to the buffer
   logic [OW-1:0]               outst_q;
   // fetches issued before a branch, their responses are dropped
   logic [OW-1:0]               stale_q;

   // tag queue of granted words, one slot per live fetch
   logic [QW-1:0]               tq_wp_q;
   logic [QW-1:0]               tq_rp_q;
   logic [pfu_pkg::WADDR_W-1:0] tq_waddr [MAX_OUTST];
   logic                        tq_skip  [MAX_OUTST];

   logic [OW:0]                 inflight;
   logic                        grant;
   logic                        rsp_stale;
   logic                        rsp_live;

   // wrap for a queue depth that need not be a power of two
   function automatic logic [QW-1:0] tq_next(input logic [QW-1:0] ptr);
      return (ptr == QW'(MAX_OUTST - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ----------------------------------------------------------------------
   // request and response steering
   // ----------------------------------------------------------------------

   assign inflight = {1'b0, outst_q} + {1'b0, stale_q};

   // no request in a branch cycle, the old address is dead
   assign fetch_req_o  = run_q & (credits_q != '0) & (inflight < (OW + 1)'(MAX_OUTST)) &
                         ~branch_i;
   assign fetch_addr_o = next_waddr_q;
   assign grant        = fetch_req_o & fetch_gnt_i;

   // stale responses always come first, they were granted earlier
   assign rsp_stale = rsp_valid_i & (stale_q != '0);
   assign rsp_live  = rsp_valid_i & (stale_q == '0);

   // a response racing a branch is lost with the flush
   assign wr.wr_valid = rsp_live & ~branch_i;
   assign wr.wr_entry = '{waddr:   tq_waddr[tq_rp_q],
                          data:    rsp_rdata_i,
                          err:     rsp_err_i,
                          bkpt:    rsp_bkpt_i,
                          skip_lo: tq_skip[tq_rp_q]};
   assign wr.flush    = branch_i;

   // ----------------------------------------------------------------------
   // counters and fetch address
   // ----------------------------------------------------------------------

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         run_q        <= 1'b0;
         next_waddr_q <= pfu_pkg::RESET_HADDR[pfu_pkg::HADDR_W-1:1];
         skip_pend_q  <= pfu_pkg::RESET_HADDR[0];
         credits_q    <= CW'(IBUF_WORDS);
         outst_q      <= '0;
         stale_q      <= '0;
         tq_wp_q      <= '0;
         tq_rp_q      <= '0;
      end else begin
         run_q <= 1'b1;
         if (branch_i) begin
            // restart at the target, buffer is empty after this edge
            next_waddr_q <= branch_target_i[pfu_pkg::HADDR_W-1:1];
            skip_pend_q  <= branch_target_i[0];
            credits_q    <= CW'(IBUF_WORDS);
            outst_q      <= '0;
            // everything still in flight is now stale
            stale_q      <= stale_q + outst_q - OW'(rsp_valid_i);
            tq_wp_q      <= '0;
            tq_rp_q      <= '0;
         end else begin
            if (grant) begin
               next_waddr_q <= next_waddr_q + 1'b1;
               skip_pend_q  <= 1'b0;
               tq_wp_q      <= tq_next(tq_wp_q);
            end
            if (rsp_live) begin
               tq_rp_q <= tq_next(tq_rp_q);
            end
            credits_q <= credits_q - CW'(grant) + CW'(wr.credit_ret);
            outst_q   <= outst_q + OW'(grant) - OW'(rsp_live);
            stale_q   <= stale_q - OW'(rsp_stale);
         end
      end
   end

   // tag payload
   always_ff @(posedge hclk) begin
      if (grant) begin
         tq_waddr[tq_wp_q] <= next_waddr_q;
         tq_skip[tq_wp_q]  <= skip_pend_q;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // buffer returns no more credits than were spent
   a_credit_max: assert property (@(posedge hclk) disable iff (!hreset_n)
      credits_q <= CW'(IBUF_WORDS));

   // live plus stale fetches stay within the limit, so the live count does too
   a_outst_max: assert property (@(posedge hclk) disable iff (!hreset_n)
      inflight <= (OW + 1)'(MAX_OUTST));

endmodule

`default_nettype wire

// ==== hdl/pfu_ibuf.sv ====
// word FIFO; IBUF_WORDS must be a power of two >= 2, writes are trusted to hold a credit
`default_nettype none

module pfu_ibuf #(
   parameter int IBUF_WORDS = 4
) (
   input  wire      hclk,
   input  wire      hreset_n,
   pfu_wr_if.buffer wr,
   pfu_rd_if.buffer rd
);

   localparam int AW = $clog2(IBUF_WORDS);

   // ----------------------------------------------------------------------
   // storage and pointers
   // ----------------------------------------------------------------------

   // extra msb tells full from empty
   logic [AW:0]          wp_q;
   logic [AW:0]          rp_q;
   pfu_pkg::ibuf_entry_t mem [IBUF_WORDS];

   logic                 empty;
   logic                 full;
   logic                 pop;

   assign empty = (wp_q == rp_q);
   assign full  = (wp_q[AW] != rp_q[AW]) && (wp_q[AW-1:0] == rp_q[AW-1:0]);

   // ignore a pop against an empty buffer
   assign pop   = rd.rd_pop & ~empty;

   // ----------------------------------------------------------------------
   // read side
   // ----------------------------------------------------------------------

   // head entry straight from the array, valid the cycle after its write
   assign rd.rd_valid = ~empty;
   assign rd.rd_entry = mem[rp_q[AW-1:0]];

   // each freed entry goes back to the producer as a credit
   // a pop in a flush cycle is harmless, the producer reloads its credits
   assign wr.credit_ret = pop;

   // ----------------------------------------------------------------------
   // pointer update
   // ----------------------------------------------------------------------

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         wp_q <= '0;
         rp_q <= '0;
      end else if (wr.flush) begin
         // branch, drop every entry at once
         wp_q <= '0;
         rp_q <= '0;
      end else begin
         if (wr.wr_valid) begin
            wp_q <= wp_q + 1'b1;
         end
         if (pop) begin
            rp_q <= rp_q + 1'b1;
         end
      end
   end

   // entry payload
   always_ff @(posedge hclk) begin
      if (wr.wr_valid) begin
         mem[wp_q[AW-1:0]] <= wr.wr_entry;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // credit accounting in the producer keeps writes away from a full buffer
   a_no_overflow: assert property (@(posedge hclk) disable iff (!hreset_n)
      wr.wr_valid |-> !full);

endmodule

`default_nettype wire

// ==== hdl/pfu_op_issue.sv ====
// opcode issue; decoder must not take an opcode in a branch cycle, op_valid_o may drop on a flush
`default_nettype none

module pfu_op_issue (
   input  wire                         hclk,
   input  wire                         hreset_n,
   pfu_rd_if.consumer                  rd,
   output logic                        op_valid_o,
   output logic [15:0]                 op_o,
   output logic                        op_special_o,
   output logic [pfu_pkg::HADDR_W-1:0] op_addr_o,
   input  wire                         op_ready_i
);

   // which half of the head word is offered
   typedef enum logic {
      HALF_LO = 1'b0,
      HALF_HI = 1'b1
   } half_e;

   half_e             half_q;
   half_e             half_sel;
   pfu_pkg::op_kind_e kind;
   logic              bkpt_hit;
   logic              take;

   // ----------------------------------------------------------------------
   // halfword select and classification
   // ----------------------------------------------------------------------

   always_comb begin
      // a halfword-aligned branch target starts on the upper half
      half_sel = half_q;
      if (rd.rd_entry.skip_lo) begin
         half_sel = HALF_HI;
      end

      bkpt_hit = (half_sel == HALF_HI) ? rd.rd_entry.bkpt[1] : rd.rd_entry.bkpt[0];

      // breakpoint over fault over plain instruction
      if (bkpt_hit) begin
         kind = pfu_pkg::OP_BKPT;
      end else if (rd.rd_entry.err) begin
         kind = pfu_pkg::OP_FAULT;
      end else begin
         kind = pfu_pkg::OP_INSTR;
      end

      case (kind)
         pfu_pkg::OP_BKPT:  op_o = pfu_pkg::BKPT_OPCODE;
         pfu_pkg::OP_FAULT: op_o = pfu_pkg::FAULT_OPCODE;
         default: begin
            op_o = (half_sel == HALF_HI) ? rd.rd_entry.data[31:16] : rd.rd_entry.data[15:0];
         end
      endcase
   end

   assign op_special_o = (kind != pfu_pkg::OP_INSTR);
   assign op_addr_o    = {rd.rd_entry.waddr, half_sel == HALF_HI};

   // no added latency, the buffer head is the offered opcode
   assign op_valid_o   = rd.rd_valid;
   assign take         = rd.rd_valid & op_ready_i;

   // word is done once its upper half goes
   assign rd.rd_pop    = take & (half_sel == HALF_HI);

   // ----------------------------------------------------------------------
   // half state
   // ----------------------------------------------------------------------

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         half_q <= HALF_LO;
      end else if (!rd.rd_valid) begin
         // empty buffer, next word starts fresh
         half_q <= HALF_LO;
      end else if (take) begin
         half_q <= (half_sel == HALF_LO) ? HALF_HI : HALF_LO;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // after a pop the head is the next word of the same stream
   // a flush can not come with a pop, so any new head follows the popped word
   a_pop_next: assert property (@(posedge hclk) disable iff (!hreset_n)
      rd.rd_pop |=> !rd.rd_valid ||
                    (rd.rd_entry.waddr == $past(rd.rd_entry.waddr) + 1'b1));

endmodule

`default_nettype wire

// ==== hdl/pfu_top.sv ====
// prefetch unit top; IBUF_WORDS a power of two >= 2, fetch bus returns responses in grant order
`default_nettype none

module pfu_top #(
   parameter int IBUF_WORDS = 4,
   parameter int MAX_OUTST  = 2
) (
   input  wire                         hclk,
   input  wire                         hreset_n,

   // fetch bus, address phase
   output logic                        fetch_req_o,
   output logic [pfu_pkg::WADDR_W-1:0] fetch_addr_o,
   input  wire                         fetch_gnt_i,

   // fetch bus, response phase
   input  wire                         rsp_valid_i,
   input  wire [31:0]                  rsp_rdata_i,
   input  wire                         rsp_err_i,
   input  wire [1:0]                   rsp_bkpt_i,

   // redirect
   input  wire                         branch_i,
   input  wire [pfu_pkg::HADDR_W-1:0]  branch_target_i,

   // decoder side
   output logic                        op_valid_o,
   output logic [15:0]                 op_o,
   output logic                        op_special_o,
   output logic [pfu_pkg::HADDR_W-1:0] op_addr_o,
   input  wire                         op_ready_i
);

   // ----------------------------------------------------------------------
   // internal bundles
   // ----------------------------------------------------------------------

   pfu_wr_if u_wr_if ();
   pfu_rd_if u_rd_if ();

   // ----------------------------------------------------------------------
   // fetch producer, word buffer, opcode issue
   // ----------------------------------------------------------------------

   pfu_fetch_gen #(
      .IBUF_WORDS (IBUF_WORDS),
      .MAX_OUTST  (MAX_OUTST)
   ) u_fetch_gen (
      .hclk            (hclk),
      .hreset_n        (hreset_n),
      .branch_i        (branch_i),
      .branch_target_i (branch_target_i),
      .fetch_req_o     (fetch_req_o),
      .fetch_addr_o    (fetch_addr_o),
      .fetch_gnt_i     (fetch_gnt_i),
      .rsp_valid_i     (rsp_valid_i),
      .rsp_rdata_i     (rsp_rdata_i),
      .rsp_err_i       (rsp_err_i),
      .rsp_bkpt_i      (rsp_bkpt_i),
      .wr              (u_wr_if.producer)
   );

   pfu_ibuf #(
      .IBUF_WORDS (IBUF_WORDS)
   ) u_ibuf (
      .hclk     (hclk),
      .hreset_n (hreset_n),
      .wr       (u_wr_if.buffer),
      .rd       (u_rd_if.buffer)
   );

   pfu_op_issue u_op_issue (
      .hclk         (hclk),
      .hreset_n     (hreset_n),
      .rd           (u_rd_if.consumer),
      .op_valid_o   (op_valid_o),
      .op_o         (op_o),
      .op_special_o (op_special_o),
      .op_addr_o    (op_addr_o),
      .op_ready_i   (op_ready_i)
   );

endmodule

`default_nettype wire

// ==== tb/pfu_tb.sv ====
// random prefetch testbench; memory is a scramble of the word address, bus keeps grant order
`default_nettype none

module pfu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HW         = pfu_pkg::HADDR_W;
   localparam int WW         = pfu_pkg::WADDR_W;
   localparam int N_OPS      = 2000;
   localparam int IDLE_LIMIT = 400;
   localparam int MAX_CYCLES = 40000;

   logic          hclk;
   logic          hreset_n;
   logic          fetch_req_o;
   logic [WW-1:0] fetch_addr_o;
   logic          fetch_gnt_i;
   logic          rsp_valid_i;
   logic [31:0]   rsp_rdata_i;
   logic          rsp_err_i;
   logic [1:0]    rsp_bkpt_i;
   logic          branch_i;
   logic [HW-1:0] branch_target_i;
   logic          op_valid_o;
   logic [15:0]   op_o;
   logic          op_special_o;
   logic [HW-1:0] op_addr_o;
   logic          op_ready_i;

   // bus model, granted word addresses and the cycle each answer is due
   logic [WW-1:0] pend_addr [$];
   int            pend_due  [$];
   int            last_due;
   int            cyc;

   // reference model state and bookkeeping
   logic [HW-1:0] exp_haddr;
   string         stream;
   int            n_issued;
   int            n_checks;
   int            n_val_err;
   int            n_other_err;
   int            n_fault;
   int            n_bkpt;
   int            n_bkpt_err;
   int            n_br_word;
   int            n_br_half;

   pfu_top #(
      .IBUF_WORDS (4),
      .MAX_OUTST  (2)
   ) u_dut (
      .hclk            (hclk),
      .hreset_n        (hreset_n),
      .fetch_req_o     (fetch_req_o),
      .fetch_addr_o    (fetch_addr_o),
      .fetch_gnt_i     (fetch_gnt_i),
      .rsp_valid_i     (rsp_valid_i),
      .rsp_rdata_i     (rsp_rdata_i),
      .rsp_err_i       (rsp_err_i),
      .rsp_bkpt_i      (rsp_bkpt_i),
      .branch_i        (branch_i),
      .branch_target_i (branch_target_i),
      .op_valid_o      (op_valid_o),
      .op_o            (op_o),
      .op_special_o    (op_special_o),
      .op_addr_o       (op_addr_o),
      .op_ready_i      (op_ready_i)
   );

   // ----------------------------------------------------------------------
   // memory rules
   // ----------------------------------------------------------------------

   // scramble over all address bits
   function automatic logic [31:0] mem_data(input logic [WW-1:0] waddr);
      return (32'(waddr) * 32'h9E37_79B1) + 32'h1234_5677;
   endfunction

   // every 13th word faults
   function automatic logic mem_err(input logic [WW-1:0] waddr);
      return (32'(waddr) % 13) == 0;
   endfunction

   function automatic logic bkpt_at(input logic [HW-1:0] haddr);
      return (32'(haddr) % 11) == 0;
   endfunction

   // bit 1 upper half, bit 0 lower half
   function automatic logic [1:0] mem_bkpt(input logic [WW-1:0] waddr);
      return {bkpt_at({waddr, 1'b1}), bkpt_at({waddr, 1'b0})};
   endfunction

   // breakpoint beats fault beats plain instruction
   function automatic pfu_pkg::op_kind_e exp_kind(input logic [HW-1:0] haddr);
      if (bkpt_at(haddr)) begin
         return pfu_pkg::OP_BKPT;
      end
      if (mem_err(haddr[HW-1:1])) begin
         return pfu_pkg::OP_FAULT;
      end
      return pfu_pkg::OP_INSTR;
   endfunction

   function automatic logic [15:0] exp_opcode(input logic [HW-1:0] haddr);
      logic [31:0] data;
      data = mem_data(haddr[HW-1:1]);
      case (exp_kind(haddr))
         pfu_pkg::OP_BKPT:  return pfu_pkg::BKPT_OPCODE;
         pfu_pkg::OP_FAULT: return pfu_pkg::FAULT_OPCODE;
         default:           return haddr[0] ? data[31:16] : data[15:0];
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------

   task automatic check_opcode(input string name, input pfu_pkg::op_kind_e kind,
                               input logic [15:0] exp_op, input logic [15:0] act_op,
                               input logic act_special);
      logic exp_special;
      exp_special = (kind != pfu_pkg::OP_INSTR);
      n_checks++;
      if (act_op !== exp_op || act_special !== exp_special) begin
         n_val_err++;
         $display("CHECK FAILED %s opcode: expected %s %h special %b, actual %h special %b",
                  name, kind.name(), exp_op, exp_special, act_op, act_special);
      end
   endtask

   task automatic check_addr(input string name, input logic [HW-1:0] exp_a,
                             input logic [HW-1:0] act_a);
      n_checks++;
      if (act_a !== exp_a) begin
         n_val_err++;
         $display("CHECK FAILED %s address: expected %h, actual %h", name, exp_a, act_a);
      end
   endtask

   task automatic check_flag(input string name, input logic exp_f, input logic act_f);
      n_checks++;
      if (act_f !== exp_f) begin
         n_val_err++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp_f, act_f);
      end
   endtask

   // ----------------------------------------------------------------------
   // clock
   // ----------------------------------------------------------------------

   initial begin
      hclk = 1'b0;
      forever #50 hclk = ~hclk;
   end

   // ----------------------------------------------------------------------
   // bus model, decoder model and opcode checker
   // ----------------------------------------------------------------------

   // everything read here is the value of the cycle that just ended
   always @(posedge hclk) begin : model
      logic [WW-1:0] wa;
      logic [HW-1:0] tgt;
      int            due;
      if (!hreset_n) begin
         fetch_gnt_i <= 1'b0;
         rsp_valid_i <= 1'b0;
         rsp_rdata_i <= '0;
         rsp_err_i   <= 1'b0;
         rsp_bkpt_i  <= '0;
         branch_i    <= 1'b0;
         op_ready_i  <= 1'b0;
         pend_addr.delete();
         pend_due.delete();
         last_due  = 0;
         cyc       = 0;
         exp_haddr = pfu_pkg::RESET_HADDR;
         stream    = "reset stream";
      end else begin
         cyc = cyc + 1;
         // a branch restarts the expected stream at its target
         if (branch_i) begin
            exp_haddr = branch_target_i;
            stream    = branch_target_i[0] ? "halfword target" : "word target";
         end else if (op_valid_o && op_ready_i) begin
            check_addr(stream, exp_haddr, op_addr_o);
            check_opcode(stream, exp_kind(exp_haddr), exp_opcode(exp_haddr), op_o,
                         op_special_o);
            if (exp_kind(exp_haddr) == pfu_pkg::OP_FAULT) begin
               n_fault++;
            end
            if (exp_kind(exp_haddr) == pfu_pkg::OP_BKPT) begin
               n_bkpt++;
               if (mem_err(exp_haddr[HW-1:1])) begin
                  n_bkpt_err++;
               end
            end
            exp_haddr = exp_haddr + 1'b1;
            n_issued++;
            if (stream != "reset stream") begin
               stream = "sequential after branch";
            end
         end

         // accepted fetch, answer 1 to 4 cycles later and never out of order
         if (fetch_req_o && fetch_gnt_i) begin
            due = cyc + int'($urandom_range(0, 3));
            if (due <= last_due) begin
               due = last_due + 1;
            end
            pend_addr.push_back(fetch_addr_o);
            pend_due.push_back(due);
            last_due = due;
         end
         if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
            wa = pend_addr.pop_front();
            due = pend_due.pop_front();
            rsp_valid_i <= 1'b1;
            rsp_rdata_i <= mem_data(wa);
            rsp_err_i   <= mem_err(wa);
            rsp_bkpt_i  <= mem_bkpt(wa);
         end else begin
            rsp_valid_i <= 1'b0;
            rsp_rdata_i <= '0;
            rsp_err_i   <= 1'b0;
            rsp_bkpt_i  <= '0;
         end

         fetch_gnt_i <= ($urandom_range(0, 3) != 0);
         // branches only once the reset stream has been seen for a while
         // the decoder holds off in the branch cycle
         if (n_issued >= 50 && $urandom_range(0, 39) == 0) begin
            tgt = ($urandom_range(0, 1) == 0) ? HW'($urandom_range(0, 4095)) : HW'($urandom());
            branch_i        <= 1'b1;
            branch_target_i <= tgt;
            op_ready_i      <= 1'b0;
            if (tgt[0]) begin
               n_br_half++;
            end else begin
               n_br_word++;
            end
         end else begin
            branch_i   <= 1'b0;
            op_ready_i <= ($urandom_range(0, 3) != 0);
         end
      end
   end

   // ----------------------------------------------------------------------
   // run control
   // ----------------------------------------------------------------------

   initial begin : run
      int idle;
      int last_issued;
      int n_cyc;
      void'($urandom(23));
      hreset_n        = 1'b0;
      fetch_gnt_i     = 1'b0;
      rsp_valid_i     = 1'b0;
      rsp_rdata_i     = '0;
      rsp_err_i       = 1'b0;
      rsp_bkpt_i      = '0;
      branch_i        = 1'b0;
      branch_target_i = '0;
      op_ready_i      = 1'b0;
      n_issued        = 0;
      n_checks        = 0;
      n_val_err       = 0;
      n_other_err     = 0;
      n_fault         = 0;
      n_bkpt          = 0;
      n_bkpt_err      = 0;
      n_br_word       = 0;
      n_br_half       = 0;

      // outputs stay quiet for all 8 reset cycles
      for (int i = 0; i < 8; i++) begin
         @(negedge hclk);
         check_flag("fetch_req_o in reset", 1'b0, fetch_req_o);
         check_flag("op_valid_o in reset", 1'b0, op_valid_o);
      end
      @(posedge hclk);
      hreset_n <= 1'b1;

      idle        = 0;
      last_issued = 0;
      n_cyc       = 0;
      while (n_issued < N_OPS && idle < IDLE_LIMIT && n_cyc < MAX_CYCLES) begin
         @(posedge hclk);
         n_cyc++;
         if (n_issued != last_issued) begin
            last_issued = n_issued;
            idle        = 0;
         end else begin
            idle++;
         end
      end

      if (n_issued < N_OPS) begin
         n_other_err++;
         $display("ERROR: only %0d of %0d opcodes issued before the timeout", n_issued, N_OPS);
      end
      if (n_br_word == 0 || n_br_half == 0) begin
         n_other_err++;
         $display("ERROR: branches to both word and halfword targets were not exercised");
      end
      if (n_fault == 0 || n_bkpt == 0 || n_bkpt_err == 0) begin
         n_other_err++;
         $display("ERROR: fault, breakpoint or breakpoint-in-fault opcodes were not seen");
      end

      $display("opcodes %0d, checks %0d, value errors %0d, other errors %0d",
               n_issued, n_checks, n_val_err, n_other_err);
      if (n_val_err == 0 && n_other_err == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== pfu_top.f ====
hdl/pfu_pkg.sv
hdl/pfu_if.sv
hdl/pfu_fetch_gen.sv
hdl/pfu_ibuf.sv
hdl/pfu_op_issue.sv
hdl/pfu_top.sv
tb/pfu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pfu_tb -f pfu_top.f \
   -o pfu_sim > build.log 2>&1 &&
   ./obj_dir/pfu_sim > sim.log 2>&1 ||
   echo "build or simulation did not complete, see build.log and sim.log"
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
